/* source/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int DIV_CNT_W  = 6;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_FENCE  = 7'b0001111
    } rv_opcode_e;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_FENCE
    } ex_op_e;

    // compare vector from issue stage
    localparam int CMP_EQ  = 0;
    localparam int CMP_GEU = 1;
    localparam int CMP_GE  = 2;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

endpackage

/* source/exu_if.sv */
`timescale 1ns/1ns

// one decoded operation, decoder to functional units
interface exu_if;
    import ex_pkg::*;

    ex_op_e          op;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [2:0]      cmp;  // eq, geu, ge

    modport source (output op, op1, op2, cmp);
    modport sink (input op, op1, op2, cmp);

endinterface

/* source/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    exu_if.sink                     u,
    output logic [ex_pkg::XLEN-1:0] alu_result_o
);
    import ex_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = u.op2[SHAMT_W-1:0];

    always_comb begin
        case (u.op)
            OP_ADD:  alu_result_o = u.op1 + u.op2;
            OP_SUB:  alu_result_o = u.op1 - u.op2;
            OP_SLL:  alu_result_o = u.op1 << shamt;
            // issue stage already compared, lt is just not ge
            OP_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, ~u.cmp[CMP_GE]};
            OP_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, ~u.cmp[CMP_GEU]};
            OP_XOR:  alu_result_o = u.op1 ^ u.op2;
            OP_SRL:  alu_result_o = u.op1 >> shamt;
            OP_SRA:  alu_result_o = $unsigned($signed(u.op1) >>> shamt);  // sign fill
            OP_OR:   alu_result_o = u.op1 | u.op2;
            OP_AND:  alu_result_o = u.op1 & u.op2;
            default: alu_result_o = '0;
        endcase
    end

endmodule

/* source/ex_mul.sv */
`timescale 1ns/1ns

module ex_mul (
    exu_if.sink                     u,
    output logic [ex_pkg::XLEN-1:0] mul_result_o
);
    import ex_pkg::*;

    logic [XLEN-1:0]   a_abs;
    logic [XLEN-1:0]   b_abs;
    logic              neg;
    logic [2*XLEN-1:0] prod;
    logic [2*XLEN-1:0] prod_fix;

    always_comb begin
        a_abs = u.op1;
        b_abs = u.op2;
        neg   = 1'b0;
        case (u.op)
            OP_MULH: begin
                a_abs = u.op1[XLEN-1] ? -u.op1 : u.op1;
                b_abs = u.op2[XLEN-1] ? -u.op2 : u.op2;
                neg   = u.op1[XLEN-1] ^ u.op2[XLEN-1];
            end
            OP_MULHSU: begin
                a_abs = u.op1[XLEN-1] ? -u.op1 : u.op1;  // op2 stays unsigned
                neg   = u.op1[XLEN-1];
            end
            default: ;  // mul low half is sign agnostic
        endcase
        prod         = {{XLEN{1'b0}}, a_abs} * {{XLEN{1'b0}}, b_abs};
        prod_fix     = neg ? -prod : prod;
        mul_result_o = (u.op == OP_MUL) ? prod_fix[XLEN-1:0] : prod_fix[2*XLEN-1:XLEN];
    end

endmodule

/* source/ex_div.sv */
`timescale 1ns/1ns

module ex_div (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    exu_if.sink                     u,
    input  logic                    div_valid_i,
    output logic [ex_pkg::XLEN-1:0] div_result_o,
    output logic                    div_ready_o
);
    import ex_pkg::*;

    div_state_e         state;
    logic [DIV_CNT_W-1:0] cnt;
    logic               signed_op;
    logic               want_rem;
    logic               neg_quo;
    logic               neg_rem;
    logic [XLEN-1:0]    dvs_q;   // divisor magnitude
    logic [XLEN-1:0]    quo_q;   // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]    rem_q;
    logic [XLEN-1:0]    result_q;
    logic [XLEN:0]      part;
    logic [XLEN:0]      diff;
    logic               fits;

    assign signed_op = (u.op == OP_DIV) || (u.op == OP_REM);

    always_comb begin
        part = {rem_q, quo_q[XLEN-1]};
        diff = part - {1'b0, dvs_q};
        fits = ~diff[XLEN];  // no borrow
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (div_valid_i) begin
                        state <= DIV_BUSY;
                        cnt   <= '0;
                    end
                end
                DIV_BUSY: begin
                    if (!div_valid_i) state <= DIV_IDLE;  // dropped by interrupt
                    else if (cnt == DIV_CNT_W'(XLEN)) state <= DIV_DONE;
                    else cnt <= cnt + 1'b1;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == DIV_IDLE && div_valid_i) begin
            want_rem <= (u.op == OP_REM) || (u.op == OP_REMU);
            // zero divisor keeps the quotient all ones
            neg_quo  <= signed_op && (u.op1[XLEN-1] ^ u.op2[XLEN-1]) && (u.op2 != '0);
            neg_rem  <= signed_op && u.op1[XLEN-1];
            quo_q    <= (signed_op && u.op1[XLEN-1]) ? -u.op1 : u.op1;
            dvs_q    <= (signed_op && u.op2[XLEN-1]) ? -u.op2 : u.op2;
            rem_q    <= '0;
        end else if (state == DIV_BUSY) begin
            if (cnt != DIV_CNT_W'(XLEN)) begin
                rem_q <= fits ? diff[XLEN-1:0] : part[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], fits};
            end else begin
                // most negative over -1 falls out of the magnitudes unchanged
                result_q <= want_rem ? (neg_rem ? -rem_q : rem_q)
                                     : (neg_quo ? -quo_q : quo_q);
            end
        end
    end

    assign div_result_o = result_q;
    assign div_ready_o  = (state == DIV_DONE);

endmodule

/* source/ex_lsu.sv */
`timescale 1ns/1ns

module ex_lsu (
    exu_if.sink                     u,
    input  logic [ex_pkg::XLEN-1:0] mem_rdata_i,
    input  logic [ex_pkg::XLEN-1:0] store_data_i,
    output logic [ex_pkg::XLEN-1:0] lsu_rdata_o,
    output logic [ex_pkg::XLEN-1:0] mem_addr_o,
    output logic [ex_pkg::XLEN-1:0] mem_wdata_o,
    output logic                    mem_we_o,
    output logic                    mem_req_o
);
    import ex_pkg::*;

    logic [1:0]  idx;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign mem_addr_o = u.op1 + u.op2;
    assign idx        = mem_addr_o[1:0];

    always_comb begin
        rd_byte     = mem_rdata_i[{idx, 3'b000} +: 8];
        rd_half     = idx[1] ? mem_rdata_i[XLEN-1:16] : mem_rdata_i[15:0];
        lsu_rdata_o = mem_rdata_i;
        mem_wdata_o = store_data_i;
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        case (u.op)
            OP_LB:  lsu_rdata_o = {{(XLEN-8){rd_byte[7]}}, rd_byte};
            OP_LH:  lsu_rdata_o = {{(XLEN-16){rd_half[15]}}, rd_half};
            OP_LBU: lsu_rdata_o = {{(XLEN-8){1'b0}}, rd_byte};
            OP_LHU: lsu_rdata_o = {{(XLEN-16){1'b0}}, rd_half};
            OP_SB: begin
                mem_wdata_o = mem_rdata_i;  // read-modify-write
                mem_wdata_o[{idx, 3'b000} +: 8] = store_data_i[7:0];
            end
            OP_SH: begin
                mem_wdata_o = mem_rdata_i;
                mem_wdata_o[{idx[1], 4'b0000} +: 16] = store_data_i[15:0];
            end
            default: ;  // lw, sw pass the whole word
        endcase
        if (u.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW})
            mem_req_o = 1'b1;
        if (u.op inside {OP_SB, OP_SH, OP_SW})
            mem_we_o = 1'b1;
    end

endmodule

/* source/ex_branch.sv */
`timescale 1ns/1ns

module ex_branch (
    exu_if.sink                     u,
    input  logic [ex_pkg::XLEN-1:0] inst_addr_next_i,
    output logic                    jump_flag_o,
    output logic [ex_pkg::XLEN-1:0] jump_addr_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] target;
    logic            take;

    assign target = u.op1 + u.op2;

    always_comb begin
        case (u.op)
            OP_BEQ:  take = u.cmp[CMP_EQ];
            OP_BNE:  take = ~u.cmp[CMP_EQ];
            OP_BLT:  take = ~u.cmp[CMP_GE];
            OP_BGE:  take = u.cmp[CMP_GE];
            OP_BLTU: take = ~u.cmp[CMP_GEU];
            OP_BGEU: take = u.cmp[CMP_GEU];
            OP_JAL:  take = 1'b1;  // jal and jalr
            default: take = 1'b0;
        endcase
        jump_flag_o = take || (u.op == OP_FENCE);
        jump_addr_o = (u.op == OP_FENCE) ? inst_addr_next_i : (take ? target : '0);
    end

endmodule

/* source/ex_top.sv */
`timescale 1ns/1ns

module ex_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [ex_pkg::XLEN-1:0]       inst_i,
    input  logic [ex_pkg::XLEN-1:0]       inst_addr_next_i,
    input  logic                          reg_we_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] reg_waddr_i,
    input  logic                          int_assert_i,
    input  logic [ex_pkg::XLEN-1:0]       int_addr_i,
    input  logic [ex_pkg::XLEN-1:0]       op1_i,
    input  logic [ex_pkg::XLEN-1:0]       op2_i,
    input  logic [2:0]                    compare_i,
    input  logic [ex_pkg::XLEN-1:0]       store_data_i,
    input  logic [ex_pkg::XLEN-1:0]       mem_rdata_i,
    input  logic                          mem_ready_i,
    output logic [ex_pkg::XLEN-1:0]       reg_wdata_o,
    output logic                          reg_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic [ex_pkg::XLEN-1:0]       mem_wdata_o,
    output logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    output logic                          mem_we_o,
    output logic                          mem_req_o,
    output logic                          ready_o,
    output logic                          jump_flag_o,
    output logic [ex_pkg::XLEN-1:0]       jump_addr_o
);
    import ex_pkg::*;

    rv_opcode_e      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    ex_op_e          op;
    logic            is_div;
    logic            div_valid;
    logic            div_ready;
    logic            lsu_req;
    logic            lsu_we;
    logic            br_flag;
    logic [XLEN-1:0] br_addr;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_result;
    logic [XLEN-1:0] div_result;
    logic [XLEN-1:0] lsu_rdata;

    exu_if exu ();

    // shared by op and op-imm, sub only exists in op
    function automatic ex_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                          input logic sub_en);
        case (f3)
            3'b000:  return (alt && sub_en) ? OP_SUB : OP_ADD;
            3'b001:  return OP_SLL;
            3'b010:  return OP_SLT;
            3'b011:  return OP_SLTU;
            3'b100:  return OP_XOR;
            3'b101:  return alt ? OP_SRA : OP_SRL;
            3'b110:  return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    assign opcode = rv_opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        op = OP_NONE;
        case (opcode)
            OPC_OP_IMM: op = alu_decode(funct3, inst_i[30], 1'b0);
            OPC_OP: begin
                if (funct7 == FUNCT7_MULDIV) begin
                    case (funct3)
                        3'b000:  op = OP_MUL;
                        3'b001:  op = OP_MULH;
                        3'b010:  op = OP_MULHSU;
                        3'b011:  op = OP_MULHU;
                        3'b100:  op = OP_DIV;
                        3'b101:  op = OP_DIVU;
                        3'b110:  op = OP_REM;
                        default: op = OP_REMU;
                    endcase
                end else if (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) begin
                    op = alu_decode(funct3, funct7 == FUNCT7_ALT, 1'b1);
                end
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_JAL, OPC_JALR:  op = OP_JAL;
            OPC_LUI, OPC_AUIPC: op = OP_ADD;  // operands prepared by issue
            OPC_FENCE:          op = OP_FENCE;
            default:            op = OP_NONE;
        endcase
    end

    assign exu.op  = op;
    assign exu.op1 = op1_i;
    assign exu.op2 = op2_i;
    assign exu.cmp = compare_i;

    ex_alu u_alu (
        .u            (exu),
        .alu_result_o (alu_result)
    );

    ex_mul u_mul (
        .u            (exu),
        .mul_result_o (mul_result)
    );

    ex_div u_div (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .u            (exu),
        .div_valid_i  (div_valid),
        .div_result_o (div_result),
        .div_ready_o  (div_ready)
    );

    ex_lsu u_lsu (
        .u            (exu),
        .mem_rdata_i  (mem_rdata_i),
        .store_data_i (store_data_i),
        .lsu_rdata_o  (lsu_rdata),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (lsu_we),
        .mem_req_o    (lsu_req)
    );

    ex_branch u_branch (
        .u                (exu),
        .inst_addr_next_i (inst_addr_next_i),
        .jump_flag_o      (br_flag),
        .jump_addr_o      (br_addr)
    );

    assign is_div    = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign div_valid = is_div && !int_assert_i;  // no divide start under interrupt

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
            OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND:   reg_wdata_o = alu_result;
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU:    reg_wdata_o = mul_result;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU:        reg_wdata_o = div_result;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:     reg_wdata_o = lsu_rdata;
            OP_JAL:                                  reg_wdata_o = inst_addr_next_i;
            default:                                 reg_wdata_o = '0;
        endcase
    end

    // interrupt override
    assign reg_we_o    = !int_assert_i && reg_we_i && (!is_div || div_ready);
    assign reg_waddr_o = reg_waddr_i;
    assign mem_req_o   = lsu_req && !int_assert_i;
    assign mem_we_o    = lsu_we && !int_assert_i;
    assign jump_flag_o = br_flag || int_assert_i;
    assign jump_addr_o = int_assert_i ? int_addr_i : br_addr;

    // stall on memory wait or a running divide
    assign ready_o = !((mem_req_o && !mem_ready_i) || (div_valid && !div_ready));

endmodule

/* bench/ex_checker.sv */
`timescale 1ns/1ns

module ex_checker (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic [2:0]  test_i,
    input logic [31:0] inst_i,
    input logic [31:0] inst_addr_next_i,
    input logic        reg_we_i,
    input logic [4:0]  reg_waddr_i,
    input logic        int_assert_i,
    input logic [31:0] int_addr_i,
    input logic [31:0] op1_i,
    input logic [31:0] op2_i,
    input logic [2:0]  compare_i,
    input logic [31:0] store_data_i,
    input logic [31:0] mem_rdata_i,
    input logic        mem_ready_i,
    input logic [31:0] reg_wdata_o,
    input logic        reg_we_o,
    input logic [4:0]  reg_waddr_o,
    input logic [31:0] mem_wdata_o,
    input logic [31:0] mem_addr_o,
    input logic        mem_we_o,
    input logic        mem_req_o,
    input logic        ready_o,
    input logic        jump_flag_o,
    input logic [31:0] jump_addr_o
);
    import ex_pkg::*;

    int         pass_cnt = 0;
    int         fail_cnt = 0;
    int         pass_mark = 0;
    int         fail_mark = 0;
    logic [2:0] last_test = '0;

    // funct3 lookup per opcode group
    ex_op_e alu_tab [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
    ex_op_e md_tab [8]  = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                            OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    ex_op_e ld_tab [8]  = '{OP_LB, OP_LH, OP_LW, OP_NONE, OP_LBU, OP_LHU, OP_NONE, OP_NONE};
    ex_op_e st_tab [8]  = '{OP_SB, OP_SH, OP_SW, OP_NONE, OP_NONE, OP_NONE, OP_NONE, OP_NONE};
    ex_op_e br_tab [8]  = '{OP_BEQ, OP_BNE, OP_NONE, OP_NONE,
                            OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

    function automatic ex_op_e decode(input logic [31:0] inst);
        logic [2:0] f3;
        logic [6:0] f7;
        ex_op_e     o;
        f3 = inst[14:12];
        f7 = inst[31:25];
        o  = OP_NONE;
        case (inst[6:0])
            OPC_OP_IMM: o = (f3 == 3'b101 && inst[30]) ? OP_SRA : alu_tab[f3];
            OPC_OP: begin
                if (f7 == FUNCT7_MULDIV) o = md_tab[f3];
                else if (f7 == FUNCT7_ALT && f3 == 3'b000) o = OP_SUB;
                else if (f7 == FUNCT7_ALT && f3 == 3'b101) o = OP_SRA;
                else if (f7 == FUNCT7_BASE || f7 == FUNCT7_ALT) o = alu_tab[f3];
            end
            OPC_LOAD:           o = ld_tab[f3];
            OPC_STORE:          o = st_tab[f3];
            OPC_BRANCH:         o = br_tab[f3];
            OPC_JAL, OPC_JALR:  o = OP_JAL;
            OPC_LUI, OPC_AUIPC: o = OP_ADD;
            OPC_FENCE:          o = OP_FENCE;
            default: ;
        endcase
        return o;
    endfunction

    function automatic logic [31:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn, input logic rem);
        logic [31:0] q;
        logic [31:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == '1) begin
            q = a;   // overflow case
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return rem ? r : q;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h, inst %h",
                     $time, what, got, exp, inst_i);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_cycle();
        ex_op_e      op;
        logic [31:0] a, b, addr, wd, mwd, ja, byte_w, half_w;
        logic [63:0] sa, sb, za, zb;
        logic        req, mwe, jf, is_div;
        op     = decode(inst_i);
        a      = op1_i;
        b      = op2_i;
        addr   = a + b;
        sa     = {{32{a[31]}}, a};
        sb     = {{32{b[31]}}, b};
        za     = {32'b0, a};
        zb     = {32'b0, b};
        byte_w = mem_rdata_i >> {addr[1:0], 3'b000};
        half_w = mem_rdata_i >> {addr[1], 4'b0000};
        req    = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
        mwe    = op inside {OP_SB, OP_SH, OP_SW};
        is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        if (int_assert_i) begin
            check("ready_o under interrupt", ready_o, 1);
            check("reg_we_o under interrupt", reg_we_o, 0);
            check("mem_req_o under interrupt", mem_req_o, 0);
            check("mem_we_o under interrupt", mem_we_o, 0);
            check("jump_flag_o under interrupt", jump_flag_o, 1);
            check("jump_addr_o under interrupt", jump_addr_o, int_addr_i);
            return;
        end
        if (req && !mem_ready_i) begin
            check("ready_o during memory wait", ready_o, 0);
            return;
        end
        if (!ready_o) begin
            if (!is_div) begin
                $display("ERROR at %0t: stage stalled with no memory wait or divide", $time);
                fail_cnt++;
            end
            check("reg_we_o while dividing", reg_we_o, 0);
            return;
        end
        wd  = '0;
        mwd = store_data_i;
        jf  = 1'b0;
        ja  = addr;
        case (op)
            OP_ADD:    wd = a + b;
            OP_SUB:    wd = a - b;
            OP_SLL:    wd = a << b[4:0];
            OP_SLT:    wd = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:   wd = {31'b0, a < b};
            OP_XOR:    wd = a ^ b;
            OP_SRL:    wd = a >> b[4:0];
            OP_SRA:    wd = $signed(a) >>> b[4:0];
            OP_OR:     wd = a | b;
            OP_AND:    wd = a & b;
            OP_MUL:    wd = 32'(za * zb);
            OP_MULH:   wd = 32'((sa * sb) >> 32);
            OP_MULHSU: wd = 32'((sa * zb) >> 32);
            OP_MULHU:  wd = 32'((za * zb) >> 32);
            OP_DIV:    wd = div_model(a, b, 1'b1, 1'b0);
            OP_DIVU:   wd = div_model(a, b, 1'b0, 1'b0);
            OP_REM:    wd = div_model(a, b, 1'b1, 1'b1);
            OP_REMU:   wd = div_model(a, b, 1'b0, 1'b1);
            OP_LB:     wd = {{24{byte_w[7]}}, byte_w[7:0]};
            OP_LBU:    wd = {24'b0, byte_w[7:0]};
            OP_LH:     wd = {{16{half_w[15]}}, half_w[15:0]};
            OP_LHU:    wd = {16'b0, half_w[15:0]};
            OP_LW:     wd = mem_rdata_i;
            OP_SB:     mwd = (mem_rdata_i & ~(32'h0000_00ff << {addr[1:0], 3'b000}))
                             | ({24'b0, store_data_i[7:0]} << {addr[1:0], 3'b000});
            OP_SH:     mwd = (mem_rdata_i & ~(32'h0000_ffff << {addr[1], 4'b0000}))
                             | ({16'b0, store_data_i[15:0]} << {addr[1], 4'b0000});
            OP_BEQ:    jf = compare_i[CMP_EQ];
            OP_BNE:    jf = !compare_i[CMP_EQ];
            OP_BLT:    jf = !compare_i[CMP_GE];
            OP_BGE:    jf = compare_i[CMP_GE];
            OP_BLTU:   jf = !compare_i[CMP_GEU];
            OP_BGEU:   jf = compare_i[CMP_GEU];
            OP_JAL: begin
                wd = inst_addr_next_i;
                jf = 1'b1;
            end
            OP_FENCE: begin
                jf = 1'b1;
                ja = inst_addr_next_i;
            end
            default: ;
        endcase
        check("reg_we_o", reg_we_o, reg_we_i);
        if (reg_we_i) begin
            check("reg_wdata_o", reg_wdata_o, wd);
            check("reg_waddr_o", reg_waddr_o, reg_waddr_i);
        end
        check("mem_req_o", mem_req_o, req);
        check("mem_we_o", mem_we_o, mwe);
        if (req) check("mem_addr_o", mem_addr_o, addr);
        if (mwe) check("mem_wdata_o", mem_wdata_o, mwd);
        check("jump_flag_o", jump_flag_o, jf);
        if (jf) check("jump_addr_o", jump_addr_o, ja);
    endtask

    always @(posedge clk_i) begin
        if (test_i != last_test) begin
            if (last_test != 0) begin
                $display("test %0d done: %0d checks passed, %0d failed", last_test,
                         pass_cnt - pass_mark, fail_cnt - fail_mark);
            end
            pass_mark = pass_cnt;
            fail_mark = fail_cnt;
            last_test = test_i;
        end
        if (rst_n_i && test_i != 0) check_cycle();
    end

endmodule

/* bench/tb_ex.sv */
`timescale 1ns/1ns

module tb_ex;
    import ex_pkg::*;

    localparam int NUM_TESTS  = 5;
    localparam int TEST_INSTS = 200;
    localparam int MAX_CYCLES = 40;   // per instruction, divide is ~35
    localparam int CLK_PERIOD = 4;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic [XLEN-1:0]   inst_i, inst_addr_next_i, int_addr_i;
    logic [XLEN-1:0]   op1_i, op2_i, store_data_i, mem_rdata_i;
    logic              reg_we_i, int_assert_i, mem_ready_i;
    logic [REG_ADDR_W-1:0] reg_waddr_i, reg_waddr_o;
    logic [2:0]        compare_i;
    logic [XLEN-1:0]   reg_wdata_o, mem_wdata_o, mem_addr_o, jump_addr_o;
    logic              reg_we_o, mem_we_o, mem_req_o, ready_o, jump_flag_o;
    logic [2:0]        test_id;
    logic [31:0]       lcg_state = 32'h31d39fd3;

    ex_top UUT (.*);

    ex_checker u_checker (.test_i(test_id), .*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [2:0] compare(input logic [31:0] x, input logic [31:0] y);
        logic [2:0] c;
        c[CMP_EQ]  = (x == y);
        c[CMP_GEU] = (x >= y);
        c[CMP_GE]  = ($signed(x) >= $signed(y));
        return c;
    endfunction

    // drive one instruction, return at the edge where it commits
    task automatic issue(input int t);
        int          kind;
        logic [31:0] r, a, b, rs1, rs2, rnd;
        logic [2:0]  f3;
        logic [6:0]  f7, opc;
        logic        we, irq, ready_seen;
        rnd  = lcg();
        kind = (t == 5) ? 1 + int'(rnd[31:30]) : t;
        r    = lcg();
        a    = lcg();
        b    = lcg();
        f3   = r[2:0];
        f7   = FUNCT7_BASE;
        we   = r[3];
        opc  = OPC_OP;
        case (kind)
            1: begin
                case (r[5:4])
                    2'd0: begin
                        f7 = r[6] ? FUNCT7_ALT : (r[7] ? FUNCT7_MULDIV : FUNCT7_BASE);
                        if (f7 == FUNCT7_MULDIV) f3[2] = 1'b0;  // multiplies only
                    end
                    2'd1: begin
                        opc = OPC_OP_IMM;
                        f7  = r[6] ? FUNCT7_ALT : FUNCT7_BASE;
                        b   = {{20{b[11]}}, b[11:0]};
                    end
                    2'd2: begin
                        opc = OPC_LUI;
                        a   = '0;
                        b   = {b[31:12], 12'b0};
                    end
                    default: begin
                        opc = OPC_AUIPC;
                        b   = {b[31:12], 12'b0};
                    end
                endcase
                rs1 = a;
                rs2 = b;
            end
            2: begin
                f7 = FUNCT7_MULDIV;
                f3 = {1'b1, r[1:0]};
                we = 1'b1;
                case (r[6:4])
                    3'd0: b = '0;
                    3'd1: begin
                        a = 32'h8000_0000;
                        b = '1;
                    end
                    3'd2: begin
                        a = a >> r[12:8];
                        b = b >> r[17:13];
                    end
                    default: ;
                endcase
                rs1 = a;
                rs2 = b;
            end
            3: begin
                b = {{20{b[11]}}, b[11:0]};
                if (r[4]) begin
                    opc = OPC_LOAD;
                    if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'b010;
                end else begin
                    opc = OPC_STORE;
                    f3  = (r[1:0] == 2'd3) ? 3'b010 : {1'b0, r[1:0]};
                    we  = 1'b0;
                end
                rs1 = a;
                rs2 = b;
            end
            default: begin
                rs1 = lcg();
                rs2 = r[7] ? rs1 : lcg();
                b   = {{19{b[12]}}, b[12:1], 1'b0};  // branch offset
                case (r[5:4])
                    2'd0, 2'd1: begin
                        opc = OPC_BRANCH;
                        if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'b000;
                        we  = 1'b0;
                    end
                    2'd2: begin
                        opc = r[6] ? OPC_JALR : OPC_JAL;
                        we  = 1'b1;
                    end
                    default: begin
                        opc = OPC_FENCE;
                        we  = 1'b0;
                    end
                endcase
            end
        endcase
        irq = (t == 5) && (r[31:30] == 2'b00);
        inst_i           <= {f7, r[17:8], f3, r[22:18], opc};
        inst_addr_next_i <= lcg();
        reg_we_i         <= we;
        reg_waddr_i      <= r[27:23];
        int_assert_i     <= irq;
        int_addr_i       <= lcg();
        op1_i            <= a;
        op2_i            <= b;
        compare_i        <= compare(rs1, rs2);
        store_data_i     <= lcg();
        mem_rdata_i      <= lcg();  // fresh word per access
        rnd = lcg();
        mem_ready_i      <= rnd[31];
        do begin
            @(posedge clk_i);
            ready_seen = ready_o;
            rnd = lcg();
            mem_ready_i <= rnd[31];
        end while (!ready_seen);
    endtask

    initial begin
        rst_n_i          = 1'b0;
        inst_i           = '0;
        inst_addr_next_i = '0;
        reg_we_i         = 1'b0;
        reg_waddr_i      = '0;
        int_assert_i     = 1'b0;
        int_addr_i       = '0;
        op1_i            = '0;
        op2_i            = '0;
        compare_i        = '0;
        store_data_i     = '0;
        mem_rdata_i      = '0;
        mem_ready_i      = 1'b1;
        test_id          = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            test_id <= 3'(t);
            for (int n = 0; n < TEST_INSTS; n++) issue(t);
        end
        test_id      <= '0;
        inst_i       <= '0;
        int_assert_i <= 1'b0;
        repeat (2) @(posedge clk_i);
        $display("checks passed: %0d, failed: %0d", u_checker.pass_cnt, u_checker.fail_cnt);
        if (u_checker.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * TEST_INSTS * MAX_CYCLES * CLK_PERIOD);
        $display("run timed out before all instructions committed");
        $display("Test failed");
        $finish;
    end

endmodule

/* vlog.f */
source/ex_pkg.sv
source/exu_if.sv
source/ex_alu.sv
source/ex_mul.sv
source/ex_div.sv
source/ex_lsu.sv
source/ex_branch.sv
source/ex_top.sv
bench/ex_checker.sv
bench/tb_ex.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex
RTL_TOP   ?= ex_top
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
